// ==== src/wbuf_params.svh ====
`ifndef WBUF_PARAMS_SVH
`define WBUF_PARAMS_SVH

////////////////////
// buffer geometry
////////////////////

// number of coalescing entries
`define WBUF_DEPTH 4
// entry index bits
`define WBUF_PTR_W 2

////////////////////
// memory side
////////////////////

// outstanding write transactions, one id each
`define WBUF_MAX_TX 2
`define WBUF_TID_W 1

// physical address and data path
`define WBUF_PLEN 32
`define WBUF_XLEN 64
`define WBUF_NBYTES 8
`define WBUF_OFF_W 3

`endif

// ==== src/wbuf_pkg.sv ====
`include "wbuf_params.svh"

package wbuf_pkg;

  // naturally aligned transfer sizes accepted by memory
  typedef enum logic [1:0] {
    SIZE_BYTE  = 2'b00,
    SIZE_HALF  = 2'b01,
    SIZE_WORD  = 2'b10,
    SIZE_DWORD = 2'b11
  } tx_size_e;

  // one write from the core, word addressed
  typedef struct packed {
    logic [`WBUF_PLEN-`WBUF_OFF_W-1:0] waddr;
    logic [`WBUF_XLEN-1:0]             data;
    logic [`WBUF_NBYTES-1:0]           be;
  } core_wr_t;

  // one buffer entry
  // per byte valid/dirty/txblock encode free, dirty, in flight, rewritten in flight
  typedef struct packed {
    logic [`WBUF_PLEN-`WBUF_OFF_W-1:0] waddr;
    logic [`WBUF_XLEN-1:0]             data;
    logic [`WBUF_NBYTES-1:0]           valid;
    logic [`WBUF_NBYTES-1:0]           dirty;
    logic [`WBUF_NBYTES-1:0]           txblock;
  } entry_t;

  // one aligned memory write, data replicated for sub-dword sizes
  typedef struct packed {
    logic [`WBUF_PLEN-1:0]   paddr;
    logic [`WBUF_XLEN-1:0]   wdata;
    tx_size_e                size;
    logic [`WBUF_TID_W-1:0]  id;
  } mem_tx_t;

  // outstanding transaction, remembers which bytes of which entry it carries
  typedef struct packed {
    logic                    vld;
    logic [`WBUF_NBYTES-1:0] be;
    logic [`WBUF_PTR_W-1:0]  ptr;
  } tx_slot_t;

endpackage

// ==== src/wbuf_entry_store.sv ====
`timescale 1ns/1ps
`include "wbuf_params.svh"

module wbuf_entry_store (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // core write port
  input  logic                                    core_req_i,
  input  wbuf_pkg::core_wr_t                      core_wr_i,
  output logic                                    core_gnt_o,
  // issue marking
  input  logic                                    issue_i,
  input  logic [`WBUF_PTR_W-1:0]                  dirty_ptr_i,
  input  logic [`WBUF_NBYTES-1:0]                 tx_be_i,
  // response eviction
  input  logic                                    evict_i,
  input  logic [`WBUF_PTR_W-1:0]                  evict_ptr_i,
  input  logic [`WBUF_NBYTES-1:0]                 evict_be_i,
  // entry view
  output wbuf_pkg::entry_t [`WBUF_DEPTH-1:0]      entries_o,
  output logic [`WBUF_DEPTH-1:0]                  ready_mask_o,
  output logic                                    empty_o
);

  // per byte state flags
  logic [`WBUF_DEPTH-1:0][`WBUF_NBYTES-1:0] valid_d, valid_q;
  logic [`WBUF_DEPTH-1:0][`WBUF_NBYTES-1:0] dirty_d, dirty_q;
  logic [`WBUF_DEPTH-1:0][`WBUF_NBYTES-1:0] txblock_d, txblock_q;
  // payload
  logic [`WBUF_DEPTH-1:0][`WBUF_PLEN-`WBUF_OFF_W-1:0] waddr_d, waddr_q;
  logic [`WBUF_DEPTH-1:0][`WBUF_XLEN-1:0] data_d, data_q;

  logic [`WBUF_DEPTH-1:0] valid_w;
  logic [`WBUF_DEPTH-1:0] hit_oh;
  logic [`WBUF_PTR_W-1:0] hit_ptr, free_ptr, wr_ptr;
  logic full, wr_en;

  ////////////////////
  // lookup
  ////////////////////

  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_flags
    assign valid_w[k] = |valid_q[k];
    assign hit_oh[k]  = valid_w[k] && (waddr_q[k] == core_wr_i.waddr);
    // entries with bytes in flight must wait, memory may reorder writes
    assign ready_mask_o[k] = (|(dirty_q[k] & valid_q[k])) && !(|txblock_q[k]);
    assign entries_o[k] = '{waddr: waddr_q[k], data: data_q[k], valid: valid_q[k],
                            dirty: dirty_q[k], txblock: txblock_q[k]};
  end

  // lowest hit and lowest free entry, scanning down so the lowest wins
  always_comb begin
    hit_ptr  = '0;
    free_ptr = '0;
    for (int k = `WBUF_DEPTH - 1; k >= 0; k--) begin
      if (hit_oh[k]) begin
        hit_ptr = k[`WBUF_PTR_W-1:0];
      end
      if (!valid_w[k]) begin
        free_ptr = k[`WBUF_PTR_W-1:0];
      end
    end
  end

  assign full       = &valid_w;
  assign core_gnt_o = (|hit_oh) || !full;
  assign wr_en      = core_req_i && core_gnt_o;
  assign wr_ptr     = (|hit_oh) ? hit_ptr : free_ptr;
  assign empty_o    = !(|valid_w);

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    valid_d   = valid_q;
    dirty_d   = dirty_q;
    txblock_d = txblock_q;
    waddr_d   = waddr_q;
    data_d    = data_q;
    // returned tx, bytes not rewritten meanwhile become free
    if (evict_i) begin
      txblock_d[evict_ptr_i] = txblock_q[evict_ptr_i] & ~evict_be_i;
      valid_d[evict_ptr_i]   = valid_q[evict_ptr_i] & ~(evict_be_i & ~dirty_q[evict_ptr_i]);
    end
    // issued bytes move from dirty to in flight
    if (issue_i) begin
      dirty_d[dirty_ptr_i]   = dirty_q[dirty_ptr_i] & ~tx_be_i;
      txblock_d[dirty_ptr_i] = txblock_q[dirty_ptr_i] | tx_be_i;
    end
    // core write last, a rewrite of an issued byte ends up 1/1/1
    if (wr_en) begin
      waddr_d[wr_ptr] = core_wr_i.waddr;
      valid_d[wr_ptr] = valid_d[wr_ptr] | core_wr_i.be;
      dirty_d[wr_ptr] = dirty_d[wr_ptr] | core_wr_i.be;
      for (int b = 0; b < `WBUF_NBYTES; b++) begin
        if (core_wr_i.be[b]) begin
          data_d[wr_ptr][b*8 +: 8] = core_wr_i.data[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      dirty_q   <= '0;
      txblock_q <= '0;
    end else begin
      valid_q   <= valid_d;
      dirty_q   <= dirty_d;
      txblock_q <= txblock_d;
    end
  end

  always_ff @(posedge clk_i) begin
    waddr_q <= waddr_d;
    data_q  <= data_d;
  end

endmodule

// ==== src/wbuf_dirty_rr.sv ====
`timescale 1ns/1ps
`include "wbuf_params.svh"

module wbuf_dirty_rr (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`WBUF_DEPTH-1:0] ready_mask_i,
  input  logic                   issue_i,
  output logic [`WBUF_PTR_W-1:0] dirty_ptr_o
);

  logic [`WBUF_PTR_W-1:0] last_q, hold_q, pick;
  logic                   lock_q;

  // search starts right after the last issued entry and wraps
  always_comb begin
    logic [`WBUF_PTR_W-1:0] idx;
    logic                   found;
    pick  = last_q;
    found = 1'b0;
    for (int i = 1; i <= `WBUF_DEPTH; i++) begin
      idx = last_q + i[`WBUF_PTR_W-1:0];
      if (!found && ready_mask_i[idx]) begin
        pick  = idx;
        found = 1'b1;
      end
    end
  end

  // a locked entry stays ready until issued
  assign dirty_ptr_o = lock_q ? hold_q : pick;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q <= 1'b0;
      hold_q <= '0;
      last_q <= '0;
    end else begin
      lock_q <= (|ready_mask_i) && !issue_i;
      hold_q <= dirty_ptr_o;
      if (issue_i) begin
        last_q <= dirty_ptr_o;
      end
    end
  end

endmodule

// ==== src/wbuf_tx_split.sv ====
`timescale 1ns/1ps
`include "wbuf_params.svh"

module wbuf_tx_split (
  input  wbuf_pkg::entry_t        entry_i,
  input  logic [`WBUF_TID_W-1:0]  tx_id_i,
  output wbuf_pkg::mem_tx_t       mem_tx_o,
  output logic [`WBUF_NBYTES-1:0] tx_be_o
);

  logic [`WBUF_NBYTES-1:0] dirty_b;
  logic [`WBUF_NBYTES-1:0] run;
  logic [`WBUF_OFF_W-1:0]  off;
  logic [`WBUF_XLEN-1:0]   slice;
  wbuf_pkg::tx_size_e      size;

  assign dirty_b = entry_i.dirty & entry_i.valid;

  // offset of lowest dirty byte
  always_comb begin
    off = '0;
    for (int b = `WBUF_NBYTES - 1; b >= 0; b--) begin
      if (dirty_b[b]) begin
        off = b[`WBUF_OFF_W-1:0];
      end
    end
  end

  // dirty bytes starting at the offset
  assign run = dirty_b >> off;

  ////////////////////
  // size selection
  ////////////////////

  // largest aligned size fully covered by dirty bytes
  // e.g. 0011_1001 gives byte at 0, then byte at 3, then half at 4
  always_comb begin
    if (off == '0 && (&run)) begin
      size = wbuf_pkg::SIZE_DWORD;
    end else if (off[1:0] == 2'b00 && (&run[3:0])) begin
      size = wbuf_pkg::SIZE_WORD;
    end else if (!off[0] && (&run[1:0])) begin
      size = wbuf_pkg::SIZE_HALF;
    end else begin
      size = wbuf_pkg::SIZE_BYTE;
    end
  end

  // data shifted down to the offset
  assign slice = entry_i.data >> {off, 3'b000};

  // replicate sub-dword data over the full bus
  always_comb begin
    mem_tx_o.paddr = {entry_i.waddr, off};
    mem_tx_o.size  = size;
    mem_tx_o.id    = tx_id_i;
    unique case (size)
      wbuf_pkg::SIZE_BYTE: begin
        mem_tx_o.wdata = {8{slice[7:0]}};
        tx_be_o        = 8'h01 << off;
      end
      wbuf_pkg::SIZE_HALF: begin
        mem_tx_o.wdata = {4{slice[15:0]}};
        tx_be_o        = 8'h03 << off;
      end
      wbuf_pkg::SIZE_WORD: begin
        mem_tx_o.wdata = {2{slice[31:0]}};
        tx_be_o        = 8'h0f << off;
      end
      default: begin
        mem_tx_o.wdata = entry_i.data;
        tx_be_o        = 8'hff;
      end
    endcase
  end

endmodule

// ==== src/wbuf_tx_tracker.sv ====
`timescale 1ns/1ps
`include "wbuf_params.svh"

module wbuf_tx_tracker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // new transaction
  input  logic                    issue_i,
  input  logic [`WBUF_PTR_W-1:0]  dirty_ptr_i,
  input  logic [`WBUF_NBYTES-1:0] tx_be_i,
  // write responses
  input  logic                    rtrn_vld_i,
  input  logic [`WBUF_TID_W-1:0]  rtrn_id_i,
  output logic [`WBUF_TID_W-1:0]  tx_id_o,
  output logic                    free_slot_o,
  // eviction towards the store
  output logic                    evict_o,
  output logic [`WBUF_PTR_W-1:0]  evict_ptr_o,
  output logic [`WBUF_NBYTES-1:0] evict_be_o
);

  wbuf_pkg::tx_slot_t [`WBUF_MAX_TX-1:0] slots_q, slots_d;

  logic [`WBUF_TID_W-1:0] free_id, held_q;
  logic                   lock_q;

  // returned id queue
  logic [`WBUF_MAX_TX-1:0][`WBUF_TID_W-1:0] fifo_q;
  logic [`WBUF_TID_W-1:0] wr_q, rd_q, rtrn_id;
  logic [`WBUF_TID_W:0]   cnt_q;

  ////////////////////
  // id choice
  ////////////////////

  always_comb begin
    free_id     = '0;
    free_slot_o = 1'b0;
    for (int i = `WBUF_MAX_TX - 1; i >= 0; i--) begin
      if (!slots_q[i].vld) begin
        free_id     = i[`WBUF_TID_W-1:0];
        free_slot_o = 1'b1;
      end
    end
  end

  // held id stays free since only an issue can take it
  assign tx_id_o = lock_q ? held_q : free_id;

  // oldest returned id is evicted, one per cycle
  assign evict_o     = (cnt_q != '0);
  assign rtrn_id     = fifo_q[rd_q];
  assign evict_ptr_o = slots_q[rtrn_id].ptr;
  assign evict_be_o  = slots_q[rtrn_id].be;

  always_comb begin
    slots_d = slots_q;
    if (evict_o) begin
      slots_d[rtrn_id].vld = 1'b0;
    end
    if (issue_i) begin
      slots_d[tx_id_o] = '{vld: 1'b1, be: tx_be_i, ptr: dirty_ptr_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slots_q <= '0;
      lock_q  <= 1'b0;
      held_q  <= '0;
      wr_q    <= '0;
      rd_q    <= '0;
      cnt_q   <= '0;
    end else begin
      slots_q <= slots_d;
      lock_q  <= free_slot_o && !issue_i;
      held_q  <= tx_id_o;
      if (rtrn_vld_i) begin
        wr_q <= wr_q + 1'b1;
      end
      if (evict_o) begin
        rd_q <= rd_q + 1'b1;
      end
      cnt_q <= cnt_q + {{`WBUF_TID_W{1'b0}}, rtrn_vld_i} - {{`WBUF_TID_W{1'b0}}, evict_o};
    end
  end

  // never overflows, at most one entry per outstanding id
  always_ff @(posedge clk_i) begin
    if (rtrn_vld_i) begin
      fifo_q[wr_q] <= rtrn_id_i;
    end
  end

endmodule

// ==== src/wbuf_top.sv ====
`timescale 1ns/1ps
`include "wbuf_params.svh"

module wbuf_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // core side
  input  logic                   core_req_i,
  input  wbuf_pkg::core_wr_t     core_wr_i,
  output logic                   core_gnt_o,
  // memory write port
  output logic                   mem_req_o,
  output wbuf_pkg::mem_tx_t      mem_tx_o,
  input  logic                   mem_ack_i,
  // write responses
  input  logic                   rtrn_vld_i,
  input  logic [`WBUF_TID_W-1:0] rtrn_id_i,
  output logic                   empty_o
);

  wbuf_pkg::entry_t [`WBUF_DEPTH-1:0] entries;

  logic [`WBUF_DEPTH-1:0]  ready_mask;
  logic [`WBUF_PTR_W-1:0]  dirty_ptr, evict_ptr;
  logic [`WBUF_NBYTES-1:0] tx_be, evict_be;
  logic [`WBUF_TID_W-1:0]  tx_id;
  logic                    free_slot, evict, issue;

  // request needs an issuable entry and a free id
  assign mem_req_o = (|ready_mask) && free_slot;
  assign issue     = mem_req_o && mem_ack_i;

  wbuf_entry_store i_store (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .core_req_i  (core_req_i),
    .core_wr_i   (core_wr_i),
    .core_gnt_o  (core_gnt_o),
    .issue_i     (issue),
    .dirty_ptr_i (dirty_ptr),
    .tx_be_i     (tx_be),
    .evict_i     (evict),
    .evict_ptr_i (evict_ptr),
    .evict_be_i  (evict_be),
    .entries_o   (entries),
    .ready_mask_o(ready_mask),
    .empty_o     (empty_o)
  );

  wbuf_dirty_rr i_dirty_rr (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ready_mask_i(ready_mask),
    .issue_i     (issue),
    .dirty_ptr_o (dirty_ptr)
  );

  // splitter sees only the chosen entry
  wbuf_tx_split i_tx_split (
    .entry_i (entries[dirty_ptr]),
    .tx_id_i (tx_id),
    .mem_tx_o(mem_tx_o),
    .tx_be_o (tx_be)
  );

  wbuf_tx_tracker i_tx_tracker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .issue_i    (issue),
    .dirty_ptr_i(dirty_ptr),
    .tx_be_i    (tx_be),
    .rtrn_vld_i (rtrn_vld_i),
    .rtrn_id_i  (rtrn_id_i),
    .tx_id_o    (tx_id),
    .free_slot_o(free_slot),
    .evict_o    (evict),
    .evict_ptr_o(evict_ptr),
    .evict_be_o (evict_be)
  );

endmodule

// ==== verif/wbuf_assert.sv ====
`timescale 1ns/1ps
`include "wbuf_params.svh"

module wbuf_assert (
  input logic                                               clk_i,
  input logic                                               rst_ni,
  input logic                                               core_req_i,
  input logic                                               core_gnt_o,
  input logic [`WBUF_DEPTH-1:0]                             hit_oh,
  input logic [`WBUF_DEPTH-1:0][`WBUF_PLEN-`WBUF_OFF_W-1:0] waddr_q,
  input logic [`WBUF_DEPTH-1:0][`WBUF_NBYTES-1:0]           valid_q,
  input logic [`WBUF_DEPTH-1:0][`WBUF_NBYTES-1:0]           dirty_q,
  input logic [`WBUF_DEPTH-1:0][`WBUF_NBYTES-1:0]           txblock_q
);

  // legal byte states are 000, 110, 101 and 111
  logic [`WBUF_DEPTH-1:0][`WBUF_NBYTES-1:0] bad_bytes;
  // entries holding at least one valid byte
  logic [`WBUF_DEPTH-1:0]                   live;

  assign bad_bytes = (valid_q & ~(dirty_q | txblock_q)) |
                     (~valid_q & (dirty_q | txblock_q));

  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_live
    assign live[k] = |valid_q[k];
  end

  byte_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bad_bytes == '0)
    else $error("byte flags of an entry form an illegal state");

  // a word lives in at most one entry
  hit_at_most_one: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit_oh))
    else $error("core write hits more than one entry");

  // with every entry taken a granted write only merges, no entry changes its word
  no_grant_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (core_req_i && core_gnt_o && (&live)) |=> (waddr_q == $past(waddr_q)))
    else $error("granted write replaced a word in a full buffer");

endmodule

bind wbuf_entry_store wbuf_assert i_wbuf_assert (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .core_req_i(core_req_i),
  .core_gnt_o(core_gnt_o),
  .hit_oh    (hit_oh),
  .waddr_q   (waddr_q),
  .valid_q   (valid_q),
  .dirty_q   (dirty_q),
  .txblock_q (txblock_q)
);

// ==== verif/wbuf_tb.sv ====
`timescale 1ns/1ps
`include "wbuf_params.svh"

module wbuf_tb;

  typedef logic [`WBUF_PLEN-`WBUF_OFF_W-1:0] waddr_t;
  typedef logic [`WBUF_TID_W-1:0] tid_t;

  localparam int TIMEOUT_CYCLES = 500;
  localparam int WAIT_LIMIT     = 50;

  logic                 clk_i, rst_ni;
  logic                 core_req_i, core_gnt_o;
  wbuf_pkg::core_wr_t   core_wr_i;
  logic                 mem_req_o, mem_ack_i;
  wbuf_pkg::mem_tx_t    mem_tx_o;
  logic                 rtrn_vld_i;
  tid_t                 rtrn_id_i;
  logic                 empty_o;

  // accepted memory writes, oldest first
  wbuf_pkg::mem_tx_t    acc_q[$];
  logic                 record_en;
  logic [31:0]          lfsr_q;
  int unsigned          cycle_cnt = 0;

  wbuf_top i_wbuf_top (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .core_req_i(core_req_i),
    .core_wr_i (core_wr_i),
    .core_gnt_o(core_gnt_o),
    .mem_req_o (mem_req_o),
    .mem_tx_o  (mem_tx_o),
    .mem_ack_i (mem_ack_i),
    .rtrn_vld_i(rtrn_vld_i),
    .rtrn_id_i (rtrn_id_i),
    .empty_o   (empty_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // memory side, a transfer is taken at the edge where req and ack meet
  always @(posedge clk_i) begin
    if (record_en && mem_req_o && mem_ack_i) begin
      acc_q.push_back(mem_tx_o);
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run("run did not finish within the cycle limit");
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand64(output logic [63:0] val);
    for (int i = 0; i < 64; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val[i] = lfsr_q[0];
    end
  endtask

  // aligned transfer of nbytes at off, every lane repeats the slice
  function automatic wbuf_pkg::mem_tx_t expect_tx(input waddr_t waddr, input int off,
                                                  input int nbytes, input logic [63:0] data,
                                                  input tid_t id);
    wbuf_pkg::mem_tx_t tx;
    tx.paddr = {waddr, off[`WBUF_OFF_W-1:0]};
    tx.id    = id;
    case (nbytes)
      1:       tx.size = wbuf_pkg::SIZE_BYTE;
      2:       tx.size = wbuf_pkg::SIZE_HALF;
      4:       tx.size = wbuf_pkg::SIZE_WORD;
      default: tx.size = wbuf_pkg::SIZE_DWORD;
    endcase
    for (int i = 0; i < `WBUF_NBYTES; i++) begin
      tx.wdata[i*8 +: 8] = data[(off + (i % nbytes))*8 +: 8];
    end
    return tx;
  endfunction

  task automatic check_tx(input string name, input wbuf_pkg::mem_tx_t got,
                          input wbuf_pkg::mem_tx_t exp);
    if (got !== exp) begin
      abort_run({$sformatf("Mismatch %s: got paddr %h wdata %h size %h id %h,", name,
                           got.paddr, got.wdata, got.size, got.id),
                 $sformatf(" expected paddr %h wdata %h size %h id %h",
                           exp.paddr, exp.wdata, exp.size, exp.id)});
    end
  endtask

  task automatic check_size(input string name, input wbuf_pkg::tx_size_e got,
                            input wbuf_pkg::tx_size_e exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic start_capture();
    acc_q.delete();
    record_en = 1'b1;
  endtask

  // holds the request until granted, returns on the next falling edge
  task automatic core_write(input waddr_t waddr, input logic [63:0] data,
                            input logic [7:0] be);
    int waited;
    waited     = 0;
    core_req_i = 1'b1;
    core_wr_i  = '{waddr: waddr, data: data, be: be};
    #1;
    while (!core_gnt_o && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!core_gnt_o) begin
      abort_run("core_gnt_o never rose for a core write");
    end
    @(negedge clk_i);
    core_req_i = 1'b0;
  endtask

  task automatic return_id(input tid_t id);
    rtrn_vld_i = 1'b1;
    rtrn_id_i  = id;
    @(negedge clk_i);
    rtrn_vld_i = 1'b0;
  endtask

  task automatic wait_acc(input int n);
    int waited;
    waited = 0;
    while (acc_q.size() < n && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (acc_q.size() < n) begin
      abort_run("memory never received an expected transfer");
    end
  endtask

  task automatic wait_req();
    int waited;
    waited = 0;
    while (!mem_req_o && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!mem_req_o) begin
      abort_run("mem_req_o never rose for dirty data");
    end
  endtask

  task automatic wait_empty();
    int waited;
    waited = 0;
    while (!empty_o && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!empty_o) begin
      abort_run("empty_o never rose after all IDs returned");
    end
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic full_dword_roundtrip();
    logic [63:0] d;
    rand64(d);
    start_capture();
    mem_ack_i = 1'b1;
    core_write(29'h0000_100, d, 8'hff);
    wait_acc(1);
    mem_ack_i = 1'b0;
    // first id after reset is the lowest one
    check_tx("mem_tx_o", acc_q[0], expect_tx(29'h0000_100, 0, 8, d, '0));
    check_bit("empty_o", empty_o, 1'b0);
    return_id(acc_q[0].id);
    wait_empty();
  endtask

  task automatic coalesce_two_writes();
    logic [63:0] d_lo, d_hi, d_other;
    wbuf_pkg::mem_tx_t held;
    rand64(d_lo);
    rand64(d_hi);
    rand64(d_other);
    start_capture();
    mem_ack_i = 1'b0;
    core_write(29'h0000_200, d_lo, 8'h0f);
    core_write(29'h0000_200, d_hi, 8'hf0);
    wait_req();
    held = mem_tx_o;
    check_tx("mem_tx_o", held,
             expect_tx(29'h0000_200, 0, 8, {d_hi[63:32], d_lo[31:0]}, held.id));
    // another word turns ready while the request is held
    core_write(29'h0000_201, d_other, 8'hff);
    // back-pressure keeps the request frozen
    for (int c = 0; c < 4; c++) begin
      @(negedge clk_i);
      check_bit("mem_req_o", mem_req_o, 1'b1);
      check_tx("mem_tx_o", mem_tx_o, held);
    end
    mem_ack_i = 1'b1;
    wait_acc(2);
    mem_ack_i = 1'b0;
    check_tx("mem_tx_o", acc_q[0], held);
    check_tx("mem_tx_o", acc_q[1], expect_tx(29'h0000_201, 0, 8, d_other, acc_q[1].id));
    return_id(acc_q[0].id);
    return_id(acc_q[1].id);
    wait_empty();
  endtask

  task automatic split_aligned_bytes();
    logic [63:0] d;
    rand64(d);
    start_capture();
    mem_ack_i = 1'b1;
    core_write(29'h0000_300, d, 8'b0011_1001);
    // bytes of one entry go out one transfer at a time
    wait_acc(1);
    return_id(acc_q[0].id);
    wait_acc(2);
    return_id(acc_q[1].id);
    wait_acc(3);
    return_id(acc_q[2].id);
    wait_empty();
    mem_ack_i = 1'b0;
    check_size("mem_tx_o.size", acc_q[0].size, wbuf_pkg::SIZE_BYTE);
    check_size("mem_tx_o.size", acc_q[1].size, wbuf_pkg::SIZE_BYTE);
    check_size("mem_tx_o.size", acc_q[2].size, wbuf_pkg::SIZE_HALF);
    check_tx("mem_tx_o", acc_q[0], expect_tx(29'h0000_300, 0, 1, d, acc_q[0].id));
    check_tx("mem_tx_o", acc_q[1], expect_tx(29'h0000_300, 3, 1, d, acc_q[1].id));
    check_tx("mem_tx_o", acc_q[2], expect_tx(29'h0000_300, 4, 2, d, acc_q[2].id));
  endtask

  task automatic rewrite_in_flight();
    logic [63:0] d_old, d_new;
    rand64(d_old);
    rand64(d_new);
    start_capture();
    mem_ack_i = 1'b1;
    core_write(29'h0000_400, d_old, 8'h01);
    wait_acc(1);
    mem_ack_i = 1'b0;
    core_write(29'h0000_400, d_new, 8'h01);
    // byte is 1/1/1 now, nothing may issue before the response
    for (int c = 0; c < 4; c++) begin
      check_bit("mem_req_o", mem_req_o, 1'b0);
      @(negedge clk_i);
    end
    return_id(acc_q[0].id);
    @(negedge clk_i);
    check_bit("empty_o", empty_o, 1'b0);
    check_bit("mem_req_o", mem_req_o, 1'b1);
    mem_ack_i = 1'b1;
    wait_acc(2);
    mem_ack_i = 1'b0;
    check_tx("mem_tx_o", acc_q[1], expect_tx(29'h0000_400, 0, 1, d_new, acc_q[1].id));
    check_bit("empty_o", empty_o, 1'b0);
    return_id(acc_q[1].id);
    wait_empty();
  endtask

  task automatic fill_buffer();
    waddr_t      addr [`WBUF_DEPTH];
    logic [63:0] data [`WBUF_DEPTH];
    logic        seen [`WBUF_DEPTH];
    logic [63:0] extra;
    int          j;
    mem_ack_i = 1'b0;
    for (int i = 0; i < `WBUF_DEPTH; i++) begin
      addr[i] = 29'h0000_500 + waddr_t'(i);
      seen[i] = 1'b0;
      rand64(data[i]);
      core_write(addr[i], data[i], 8'hff);
    end
    // new word with every entry taken
    rand64(extra);
    core_req_i = 1'b1;
    core_wr_i  = '{waddr: 29'h0000_5ff, data: extra, be: 8'hff};
    for (int c = 0; c < 3; c++) begin
      #1;
      check_bit("core_gnt_o", core_gnt_o, 1'b0);
      @(negedge clk_i);
    end
    // a buffered word still merges
    core_wr_i = '{waddr: addr[1], data: extra, be: 8'h0f};
    #1;
    check_bit("core_gnt_o", core_gnt_o, 1'b1);
    @(negedge clk_i);
    core_req_i    = 1'b0;
    data[1][31:0] = extra[31:0];
    start_capture();
    mem_ack_i = 1'b1;
    for (int i = 0; i < `WBUF_DEPTH; i++) begin
      wait_acc(i + 1);
      return_id(acc_q[i].id);
    end
    wait_empty();
    mem_ack_i = 1'b0;
    // drain order follows the arbiter, so match transfers by address
    for (int i = 0; i < acc_q.size(); i++) begin
      j = -1;
      for (int k = 0; k < `WBUF_DEPTH; k++) begin
        if ({addr[k], 3'b000} == acc_q[i].paddr) begin
          j = k;
        end
      end
      if (j < 0 || seen[j]) begin
        abort_run("drained transfer does not match exactly one buffered word");
      end else begin
        seen[j] = 1'b1;
        check_tx("mem_tx_o", acc_q[i], expect_tx(addr[j], 0, 8, data[j], acc_q[i].id));
      end
    end
  endtask

  task automatic slot_limit_reorder();
    waddr_t      addr [3];
    logic [63:0] data [3];
    start_capture();
    mem_ack_i = 1'b1;
    for (int i = 0; i < 3; i++) begin
      addr[i] = 29'h0000_600 + waddr_t'(i);
      rand64(data[i]);
      core_write(addr[i], data[i], 8'hff);
      if (i < 2) begin
        wait_acc(i + 1);
      end
    end
    // both ids taken, the third word waits
    for (int c = 0; c < 4; c++) begin
      check_bit("mem_req_o", mem_req_o, 1'b0);
      @(negedge clk_i);
    end
    if (acc_q[0].id == acc_q[1].id) begin
      abort_run("two outstanding transactions carry the same ID");
    end
    // the newer id returns first, only its slot is free for the waiting word
    return_id(acc_q[1].id);
    wait_acc(3);
    check_tx("mem_tx_o", acc_q[2], expect_tx(addr[2], 0, 8, data[2], acc_q[1].id));
    return_id(acc_q[0].id);
    return_id(acc_q[2].id);
    wait_empty();
    mem_ack_i = 1'b0;
    for (int i = 0; i < 2; i++) begin
      check_tx("mem_tx_o", acc_q[i], expect_tx(addr[i], 0, 8, data[i], acc_q[i].id));
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    lfsr_q     = 32'h08179c30;
    record_en  = 1'b0;
    rst_ni     = 1'b0;
    core_req_i = 1'b0;
    core_wr_i  = '0;
    mem_ack_i  = 1'b0;
    rtrn_vld_i = 1'b0;
    rtrn_id_i  = '0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_bit("core_gnt_o", core_gnt_o, 1'b1);
    check_bit("mem_req_o", mem_req_o, 1'b0);
    check_bit("empty_o", empty_o, 1'b1);
    @(negedge clk_i);
    full_dword_roundtrip();
    coalesce_two_writes();
    split_aligned_bytes();
    rewrite_in_flight();
    fill_buffer();
    slot_limit_reorder();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== wbuf.f ====
+incdir+src
src/wbuf_pkg.sv
src/wbuf_entry_store.sv
src/wbuf_dirty_rr.sv
src/wbuf_tx_split.sv
src/wbuf_tx_tracker.sv
src/wbuf_top.sv
verif/wbuf_assert.sv
verif/wbuf_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the write buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f wbuf.f --top-module wbuf_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vwbuf_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi
exit 0
